// File: logic/clkmon_cfg_pkg.sv
package clkmon_cfg_pkg;

  // Number of observed clocks
  localparam int NUM_CLKS = 4;

  // Reference ticks with no observed edge before the clock is declared absent
  localparam int REF_TICKS_TO_ABSENCE = 10;

  // Observed edges needed before the clock is declared present
  localparam int OBS_TICKS_TO_PRESENCE = 3;

  // Length of one frequency window in reference ticks
  localparam int GATE_TICKS = 256;

  // Width of one frequency count
  localparam int FREQ_W = 16;

  // Per-channel result handed to the register block
  typedef struct packed {
    logic              present;
    logic [FREQ_W-1:0] freq;
  } chan_status_t;

endpackage

// File: logic/clkmon_wb_pkg.sv
package clkmon_wb_pkg;

  // Word address and data widths of the slave
  localparam int WB_ADR_W = 3;
  localparam int WB_DAT_W = 32;

  // Master to slave, classic cycle without byte selects
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  // Register map, word addresses
  // Present bits of every channel
  localparam logic [WB_ADR_W-1:0] ADR_STATUS = 3'd0;

  // Gained in the low half, lost in the high half, write 1 to clear
  localparam logic [WB_ADR_W-1:0] ADR_EVENT = 3'd1;

  // Interrupt mask, one bit per event bit
  localparam logic [WB_ADR_W-1:0] ADR_IRQ_EN = 3'd2;

  // First frequency register, the others follow one per channel
  localparam logic [WB_ADR_W-1:0] ADR_FREQ0 = 3'd3;

endpackage

// File: logic/clk_detect.sv
`timescale 1ns/1ps

module clk_detect #(
  parameter int REF_TICKS_TO_ABSENCE  = 10,
  parameter int OBS_TICKS_TO_PRESENCE = 3
)(
  input  logic ref_clk_i,
  input  logic rst_i,
  input  logic obs_clk_i,
  output logic present_o,
  output logic edge_o
);

  // Counters must hold the limit value itself
  localparam int ABS_CNT_W  = $clog2(REF_TICKS_TO_ABSENCE + 1);
  localparam int PRES_CNT_W = $clog2(OBS_TICKS_TO_PRESENCE + 1);

  logic                  toggle_bit = 1'b0;
  logic                  toggle_s1;
  logic                  toggle_s2;
  logic                  toggle_s3;
  logic [ABS_CNT_W-1:0]  absence_cnt;
  logic [PRES_CNT_W-1:0] presence_cnt;
  logic                  absent_next;

  // Flips on every observed rising edge, runs in the observed domain
  always_ff @(posedge obs_clk_i)
  begin
    toggle_bit <= ~toggle_bit;
  end

  // Three-flop synchronizer into the reference domain
  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      toggle_s1 <= 1'b0;
      toggle_s2 <= 1'b0;
      toggle_s3 <= 1'b0;
    end
    else
    begin
      toggle_s1 <= toggle_bit;
      toggle_s2 <= toggle_s1;
      toggle_s3 <= toggle_s2;
    end
  end

  // One pulse per observed edge
  assign edge_o = toggle_s2 ^ toggle_s3;

  // Ticks since the last edge pulse, held at the limit
  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
      absence_cnt <= '0;
    else if (edge_o)
      absence_cnt <= '0;
    else if (absence_cnt < ABS_CNT_W'(REF_TICKS_TO_ABSENCE))
      absence_cnt <= absence_cnt + 1'b1;
  end

  // High when the absence counter sits at its limit after this tick
  assign absent_next = ~edge_o && (absence_cnt >= ABS_CNT_W'(REF_TICKS_TO_ABSENCE - 1));

  // Edge pulses seen since the clock was last absent
  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
      presence_cnt <= '0;
    else if (absent_next)
      presence_cnt <= '0;
    else if (edge_o && presence_cnt < PRES_CNT_W'(OBS_TICKS_TO_PRESENCE))
      presence_cnt <= presence_cnt + 1'b1;
  end

  assign present_o = (presence_cnt == PRES_CNT_W'(OBS_TICKS_TO_PRESENCE));

endmodule

// File: logic/clk_freq_meter.sv
`timescale 1ns/1ps

module clk_freq_meter (
  input  logic                              ref_clk_i,
  input  logic                              rst_i,
  input  logic                              edge_i,
  output logic [clkmon_cfg_pkg::FREQ_W-1:0] freq_o
);

  import clkmon_cfg_pkg::*;

  logic [$clog2(GATE_TICKS)-1:0] gate_cnt;
  logic [FREQ_W-1:0]             edge_cnt;
  logic [FREQ_W-1:0]             edge_cnt_next;
  logic                          gate_wrap;

  // Last tick of the current window
  assign gate_wrap = (gate_cnt == ($clog2(GATE_TICKS))'(GATE_TICKS - 1));

  // Count including this tick's pulse, stuck at all ones
  always_comb
  begin
    edge_cnt_next = edge_cnt;
    if (edge_i && edge_cnt != '1)
      edge_cnt_next = edge_cnt + 1'b1;
  end

  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
      gate_cnt <= '0;
    else if (gate_wrap)
      gate_cnt <= '0;
    else
      gate_cnt <= gate_cnt + 1'b1;
  end

  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      edge_cnt <= '0;
      freq_o   <= '0;
    end
    else if (gate_wrap)
    begin
      // Publish the finished window and start a fresh one
      freq_o   <= edge_cnt_next;
      edge_cnt <= '0;
    end
    else
    begin
      edge_cnt <= edge_cnt_next;
    end
  end

endmodule

// File: logic/clkmon_regs.sv
`timescale 1ns/1ps

module clkmon_regs (
  input  logic                        ref_clk_i,
  input  logic                        rst_i,
  input  clkmon_wb_pkg::wb_req_t      wb_i,
  input  clkmon_cfg_pkg::chan_status_t chan_i [clkmon_cfg_pkg::NUM_CLKS],
  output clkmon_wb_pkg::wb_rsp_t      wb_o,
  output logic                        irq_o
);

  import clkmon_cfg_pkg::*;
  import clkmon_wb_pkg::*;

  logic [NUM_CLKS-1:0]   present;
  logic [NUM_CLKS-1:0]   present_q;
  logic [NUM_CLKS-1:0]   gained;
  logic [NUM_CLKS-1:0]   lost;
  logic [2*NUM_CLKS-1:0] event_set;
  logic [2*NUM_CLKS-1:0] event_clr;
  logic [2*NUM_CLKS-1:0] events;
  logic [2*NUM_CLKS-1:0] irq_en;
  logic                  ack_q;
  logic                  req;
  logic                  wr_en;
  logic [WB_DAT_W-1:0]   rd_data;
  logic [WB_DAT_W-1:0]   rd_data_q;

  // Gather the present bits of all channels
  always_comb
  begin
    for (int n = 0; n < NUM_CLKS; n++)
      present[n] = chan_i[n].present;
  end

  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
      present_q <= '0;
    else
      present_q <= present;
  end

  assign gained    = present & ~present_q;
  assign lost      = ~present & present_q;
  assign event_set = {lost, gained};

  // New access starts when the strobe is seen with ack low
  assign req = wb_i.cyc & wb_i.stb & ~ack_q;

  // Writes land at the end of the ack cycle
  assign wr_en = wb_i.cyc & wb_i.stb & wb_i.we & ack_q;

  assign event_clr = (wr_en && wb_i.adr == ADR_EVENT) ? wb_i.dat[2*NUM_CLKS-1:0] : '0;

  // Sticky events, a new set beats a clear in the same cycle
  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
      events <= '0;
    else
      events <= (events & ~event_clr) | event_set;
  end

  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
      irq_en <= '0;
    else if (wr_en && wb_i.adr == ADR_IRQ_EN)
      irq_en <= wb_i.dat[2*NUM_CLKS-1:0];
  end

  // Level interrupt from any enabled event
  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
      irq_o <= 1'b0;
    else
      irq_o <= |(events & irq_en);
  end

  // Read mux, anything unmapped reads zero
  always_comb
  begin
    rd_data = '0;
    case (wb_i.adr)
      ADR_STATUS:
        rd_data[NUM_CLKS-1:0] = present;
      ADR_EVENT:
        rd_data[2*NUM_CLKS-1:0] = events;
      ADR_IRQ_EN:
        rd_data[2*NUM_CLKS-1:0] = irq_en;
      default:
      begin
        for (int n = 0; n < NUM_CLKS; n++)
        begin
          if (wb_i.adr == WB_ADR_W'(ADR_FREQ0 + n))
            rd_data[FREQ_W-1:0] = chan_i[n].freq;
        end
      end
    endcase
  end

  // Single-cycle ack, no wait states
  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= req;
  end

  // Read data is captured together with the ack
  always_ff @(posedge ref_clk_i)
  begin
    if (req)
      rd_data_q <= rd_data;
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rd_data_q;

endmodule

// File: logic/clkmon_top.sv
`timescale 1ns/1ps

module clkmon_top (
  input  logic                                ref_clk_i,
  input  logic                                rst_i,
  input  logic [clkmon_cfg_pkg::NUM_CLKS-1:0] obs_clk_i,
  input  clkmon_wb_pkg::wb_req_t              wb_i,
  output clkmon_wb_pkg::wb_rsp_t              wb_o,
  output logic                                irq_o
);

  import clkmon_cfg_pkg::*;

  // Synchronized edge pulse per channel
  logic [NUM_CLKS-1:0] obs_edge;

  // Presence and frequency of every channel
  chan_status_t        chan [NUM_CLKS];

  for (genvar n = 0; n < NUM_CLKS; n++)
  begin : gen_chan

    clk_detect #(
      .REF_TICKS_TO_ABSENCE  (REF_TICKS_TO_ABSENCE),
      .OBS_TICKS_TO_PRESENCE (OBS_TICKS_TO_PRESENCE)
    ) detect_i (
      .ref_clk_i (ref_clk_i),
      .rst_i     (rst_i),
      .obs_clk_i (obs_clk_i[n]),
      .present_o (chan[n].present),
      .edge_o    (obs_edge[n])
    );

    clk_freq_meter meter_i (
      .ref_clk_i (ref_clk_i),
      .rst_i     (rst_i),
      .edge_i    (obs_edge[n]),
      .freq_o    (chan[n].freq)
    );

  end

  // Bus slave and interrupt
  clkmon_regs regs_i (
    .ref_clk_i (ref_clk_i),
    .rst_i     (rst_i),
    .wb_i      (wb_i),
    .chan_i    (chan),
    .wb_o      (wb_o),
    .irq_o     (irq_o)
  );

endmodule

// File: tb/clkmon_tb.sv
`timescale 1ns/1ps

module clkmon_tb;

  import clkmon_cfg_pkg::*;
  import clkmon_wb_pkg::*;

  localparam int REF_PERIOD_NS = 4;
  localparam int OBS_PERIOD_NS [NUM_CLKS] = '{12, 16, 24, 32};

  // Phase waits of the test sequence
  localparam int RUN_WAIT_NS     = 300;
  localparam int FREQ_WAIT_NS    = 1900;
  localparam int STOP_WAIT_NS    = 100;
  localparam int RESTART_WAIT_NS = 300;
  localparam int PHASE_SUM_NS    = RUN_WAIT_NS + FREQ_WAIT_NS + STOP_WAIT_NS + RESTART_WAIT_NS;

  // Bus budget per access covering idle cycles, request, ack and release
  localparam int MAX_ACCESSES   = 24;
  localparam int ACCESS_CYCLES  = 8;
  localparam int ACK_LIMIT      = 8;
  localparam int BUS_SUM_NS     = MAX_ACCESSES * ACCESS_CYCLES * REF_PERIOD_NS;
  localparam int WATCHDOG_NS    = 2 * (PHASE_SUM_NS + BUS_SUM_NS + 20 * REF_PERIOD_NS);

  logic                ref_clk;
  logic                rst;
  logic [NUM_CLKS-1:0] obs_clk;
  logic [NUM_CLKS-1:0] clk_run;
  wb_req_t             wb_i;
  wb_rsp_t             wb_o;
  logic                irq;

  // Expected state kept by the model
  logic [NUM_CLKS-1:0]   exp_present;
  logic [2*NUM_CLKS-1:0] exp_events;
  logic [2*NUM_CLKS-1:0] exp_mask;

  logic [31:0] lcg_state;

  // Pending checks for the comparing process
  string       name_q [$];
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];
  int          tol_q [$];

  clkmon_top dut_i (
    .ref_clk_i (ref_clk),
    .rst_i     (rst),
    .obs_clk_i (obs_clk),
    .wb_i      (wb_i),
    .wb_o      (wb_o),
    .irq_o     (irq)
  );

  initial
  begin
    ref_clk = 1'b0;
    forever
      #(REF_PERIOD_NS / 2) ref_clk = ~ref_clk;
  end

  // Observed clocks are offset by half a ns so they never share a step with ref_clk
  for (genvar n = 0; n < NUM_CLKS; n++)
  begin : gen_obs
    initial
    begin
      #0.5;
      forever
      begin
        #(OBS_PERIOD_NS[n] / 2);
        if (clk_run[n])
          obs_clk[n] = ~obs_clk[n];
        else
          obs_clk[n] = 1'b0;
      end
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Edges in one gate window of GATE_TICKS reference periods
  function automatic int expected_freq(input int period_ns);
    return (GATE_TICKS * REF_PERIOD_NS) / period_ns;
  endfunction

  function automatic logic model_irq();
    return |(exp_events & exp_mask);
  endfunction

  task automatic queue_check(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input int tol);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
    tol_q.push_back(tol);
  endtask

  task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DAT_W-1:0] wdata,
                            output logic [WB_DAT_W-1:0] rdata);
    int waited;
    int idle;
    waited = 0;
    lcg_state = lcg_next(lcg_state);
    idle = int'(lcg_state[17:16]);
    repeat (idle) @(posedge ref_clk);
    @(posedge ref_clk);
    wb_i.cyc <= 1'b1;
    wb_i.stb <= 1'b1;
    wb_i.we  <= we;
    wb_i.adr <= adr;
    wb_i.dat <= wdata;
    @(negedge ref_clk);
    while (!wb_o.ack)
    begin
      waited++;
      assert (waited < ACK_LIMIT)
      else
      begin
        $display("No ack from the slave at address %0d after %0d cycles", adr, waited);
        $display("Testbench failed");
        $fatal(1, "bus handshake stalled");
      end
      @(negedge ref_clk);
    end
    rdata = wb_o.dat;
    // Hold the request through the ack edge so a write lands
    @(posedge ref_clk);
    wb_i.cyc <= 1'b0;
    wb_i.stb <= 1'b0;
    wb_i.we  <= 1'b0;
  endtask

  task automatic bus_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] wdata);
    logic [WB_DAT_W-1:0] unused;
    bus_access(1'b1, adr, wdata, unused);
  endtask

  task automatic read_check(input string name, input logic [WB_ADR_W-1:0] adr,
                            input logic [31:0] exp, input int tol);
    logic [WB_DAT_W-1:0] rdata;
    bus_access(1'b0, adr, '0, rdata);
    queue_check(name, rdata, exp, tol);
  endtask

  task automatic irq_check();
    @(negedge ref_clk);
    queue_check("irq_o", {31'd0, irq}, {31'd0, model_irq()}, 0);
  endtask

  task automatic read_all_freq(input int tol, input logic use_model);
    int exp;
    for (int n = 0; n < NUM_CLKS; n++)
    begin
      exp = use_model ? expected_freq(OBS_PERIOD_NS[n]) : 0;
      read_check($sformatf("FREQ%0d", n), WB_ADR_W'(ADR_FREQ0 + n), exp, tol);
    end
  endtask

  // Comparing process
  initial
  begin
    string       name;
    logic [31:0] got;
    logic [31:0] exp;
    int          tol;
    int          diff;
    forever
    begin
      wait (tol_q.size() > 0);
      name = name_q.pop_front();
      got  = got_q.pop_front();
      exp  = exp_q.pop_front();
      tol  = tol_q.pop_front();
      diff = (got > exp) ? int'(got - exp) : int'(exp - got);
      assert (diff <= tol)
      else
      begin
        $display("mismatch at %0d ns: %s got 0x%0h expected 0x%0h (tolerance %0d)",
                 $time, name, got, exp, tol);
        $display("Testbench failed");
        $fatal(1, "check failed");
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    rst           = 1'b1;
    obs_clk       = '0;
    clk_run       = '0;
    wb_i          = '0;
    exp_present   = '0;
    exp_events    = '0;
    exp_mask      = '0;
    lcg_state     = 32'h87d1_c00f;
    repeat (3) @(posedge ref_clk);
    rst <= 1'b0;
    @(posedge ref_clk);

    // Idle state after reset with the clocks still stopped
    irq_check();
    read_check("STATUS", ADR_STATUS, 32'(exp_present), 0);
    read_check("EVENT", ADR_EVENT, 32'(exp_events), 0);
    read_check("IRQ_EN", ADR_IRQ_EN, 32'(exp_mask), 0);
    read_all_freq(0, 1'b0);
    read_check("unmapped", 3'd7, 32'd0, 0);

    // All clocks running
    clk_run = '1;
    #(RUN_WAIT_NS);
    exp_present = '1;
    exp_events  = exp_events | {{NUM_CLKS{1'b0}}, {NUM_CLKS{1'b1}}};
    read_check("STATUS", ADR_STATUS, 32'(exp_present), 0);
    read_check("EVENT", ADR_EVENT, 32'(exp_events), 0);
    irq_check();
    bus_write(ADR_IRQ_EN, 32'h0000_00a0);
    exp_mask = 8'ha0;
    read_check("IRQ_EN", ADR_IRQ_EN, 32'(exp_mask), 0);
    irq_check();

    // Frequencies once a full window has seen every clock
    #(FREQ_WAIT_NS);
    read_all_freq(1, 1'b1);

    // Losing clock 2 with only lost events enabled
    bus_write(ADR_IRQ_EN, 32'h0000_00f0);
    exp_mask = 8'hf0;
    irq_check();
    clk_run[2] = 1'b0;
    #(STOP_WAIT_NS);
    exp_present[2]  = 1'b0;
    exp_events[6]   = 1'b1;
    read_check("STATUS", ADR_STATUS, 32'(exp_present), 0);
    read_check("EVENT", ADR_EVENT, 32'(exp_events), 0);
    irq_check();

    // Clear all events and bring clock 2 back
    bus_write(ADR_EVENT, 32'h0000_00ff);
    exp_events = '0;
    repeat (2) @(posedge ref_clk);
    irq_check();
    read_check("EVENT", ADR_EVENT, 32'(exp_events), 0);
    clk_run[2] = 1'b1;
    #(RESTART_WAIT_NS);
    exp_present[2] = 1'b1;
    exp_events[2]  = 1'b1;
    read_check("STATUS", ADR_STATUS, 32'(exp_present), 0);
    read_check("EVENT", ADR_EVENT, 32'(exp_events), 0);
    irq_check();

    wait (tol_q.size() == 0);
    #1;
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: src.f
logic/clkmon_cfg_pkg.sv
logic/clkmon_wb_pkg.sv
logic/clk_detect.sv
logic/clk_freq_meter.sv
logic/clkmon_regs.sv
logic/clkmon_top.sv
tb/clkmon_tb.sv
